// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_nes_loader
FILELIST  := build.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: build.f
+incdir+sim
verilog/nes_pkg.sv
verilog/ines_decode.sv
verilog/rom_loader.sv
verilog/mem_write_port.sv
verilog/joypad_serializer.sv
verilog/session_control.sv
verilog/nes_loader_top.sv
sim/tb_nes_loader.sv

// File: sim/loader_trace.txt
# H header_bytes(byte 0 first) invert expect_ok expect_flags
# J pads(a b c d) multitap swap expect_port0 expect_port1 (bit k = k-th serial bit)
# One page PRG and CHR, vertical mirroring
H 4E45531A010101000000000000000000 0 1 00004000
# Bad magic word
H 4E45531B010101000000000000000000 0 0 00000000
# Dirty header, two PRG pages, CHR RAM, battery
H 4E45531A020012400000000044000000 0 1 02008101
# Trainer present
H 4E45531A010105000000000000000000 0 0 00000000
# NES 2.0, four screen, inverted mirroring, two CHR pages
H 4E45531A010239280500070000000000 1 1 000B0823
# Controllers without multitap
J 01100FA5 0 0 FFFF80 FFFF01
J 01100FA5 0 1 FFFF01 FFFF80
# Controllers with multitap
J 01100FA5 1 0 08F080 04AA01
J 01100FA5 1 1 08F001 04AA80
J 3CC300FF 1 0 080033 04FFCC

// File: sim/tb_checks.svh
// Testbench compare tasks for addresses, data, mapper flags, status bits and joypad bits
// Error counters and the closing count line
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int value_errors = 0;  // Wrong values seen on DUT outputs
int other_errors = 0;  // Protocol, missing writes, hold time

task automatic check_addr(input string name, input logic [MEM_ADDR_W-1:0] got,
		input logic [MEM_ADDR_W-1:0] exp);
	if (got !== exp) begin
		value_errors++;
		$display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
	end
endtask

task automatic check_data(input string name, input logic [7:0] got, input logic [7:0] exp);
	if (got !== exp) begin
		value_errors++;
		$display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
	end
endtask

task automatic check_flags(input string name, input mapper_flags_t got,
		input mapper_flags_t exp);
	if (got !== exp) begin
		value_errors++;
		$display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
	end
endtask

task automatic check_status(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		value_errors++;
		$display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
	end
endtask

// Bit k holds the k-th serial bit
task automatic check_pad_bits(input string name, input logic [PAD_SHIFT_W-1:0] got,
		input logic [PAD_SHIFT_W-1:0] exp);
	if (got !== exp) begin
		value_errors++;
		$display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
	end
endtask

task automatic check_count(input string name, input int got, input int exp);
	if (got != exp) begin
		value_errors++;
		$display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
	end
endtask

task automatic report_other(input string msg);
	other_errors++;
	$display("Error: %s at %0t", msg, $time);
endtask

task automatic print_summary();
	$display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
endtask

`endif

// File: sim/tb_nes_loader.sv
`timescale 1ns/1ns
// Testbench for the NES cartridge loader and controller ports
// Clock and reset, trace reading, memory responder, load and joypad sequences

module tb_nes_loader import nes_pkg::*; ();

	logic                  clk;
	logic                  reset_nes;
	logic                  downloading;
	logic                  byte_valid;
	logic [7:0]            byte_data;
	logic                  invert_mirroring;
	logic                  byte_wait;
	logic                  mem_req;
	logic                  mem_ack;
	logic [MEM_ADDR_W-1:0] mem_addr;
	logic [7:0]            mem_data;
	logic                  loader_busy;
	logic                  loader_done;
	logic                  loader_fail;
	logic                  console_reset;
	mapper_flags_t         mapper_flags;
	logic                  joypad_strobe;
	logic [1:0]            joypad_clock;
	logic                  multitap;
	logic                  swap;
	pad_t                  pad_a;
	pad_t                  pad_b;
	pad_t                  pad_c;
	pad_t                  pad_d;
	logic [1:0]            joypad_data;

	// Trace contents
	logic [127:0]          hdr_q [$];   // Byte 0 in the top bits
	logic                  inv_q [$];
	logic                  ok_q [$];
	mapper_flags_t         flg_q [$];
	logic [31:0]           pads_q [$];  // a, b, c, d from the top
	logic                  mt_q [$];
	logic                  sw_q [$];
	logic [23:0]           exp0_q [$];
	logic [23:0]           exp1_q [$];

	logic [MEM_ADDR_W-1:0] exp_addr_q [$];  // Writes still owed by the DUT
	logic [7:0]            exp_data_q [$];
	integer                data_seed = 32'h045d38d5;
	integer                ack_seed  = 32'h045d38d5;
	int                    handshakes = 0;
	int                    cycles = 0;
	int                    cycle_limit = 2000;
	logic                  prev_req = 1'b0;
	logic                  prev_ack = 1'b0;

	`include "tb_checks.svh"

	nes_loader_top DUT (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Run limit from the byte count of the trace
	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("Timeout: run passed %0d cycles without finishing", cycle_limit);
			$display("test failed");
			$finish;
		end
	end

	task automatic read_trace();
		int          fd;
		int          n;
		string       line;
		logic [127:0] h;
		logic [31:0] w;
		logic [3:0]  a;
		logic [3:0]  b;
		logic [23:0] e0;
		logic [23:0] e1;
		fd = $fopen("sim/loader_trace.txt", "r");
		if (fd == 0) begin
			report_other("cannot open sim/loader_trace.txt");
			return;
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 2 && line.getc(0) == "H") begin
				n = $sscanf(line.substr(2, line.len() - 1), "%h %h %h %h", h, a, b, w);
				hdr_q.push_back(h);
				inv_q.push_back(a[0]);
				ok_q.push_back(b[0]);
				flg_q.push_back(mapper_flags_t'(w));
			end else if (n > 2 && line.getc(0) == "J") begin
				n = $sscanf(line.substr(2, line.len() - 1), "%h %h %h %h %h",
				            w, a, b, e0, e1);
				pads_q.push_back(w);
				mt_q.push_back(a[0]);
				sw_q.push_back(b[0]);
				exp0_q.push_back(e0);
				exp1_q.push_back(e1);
			end
		end
		$fclose(fd);
	endtask

	// One byte from the source, then honour the wait
	task automatic send_byte(input logic [7:0] b);
		byte_data  = b;
		byte_valid = 1'b1;
		@(negedge clk);
		byte_valid = 1'b0;
		@(negedge clk);
		while (byte_wait)
			@(negedge clk);
	endtask

	////////////////////////////////////////////////////////////
	// Memory side
	////////////////////////////////////////////////////////////

	initial begin
		int ack_delay;
		forever begin
			@(negedge clk);
			if (mem_req && !mem_ack) begin
				ack_delay = int'($unsigned($random(ack_seed)) % 4);
				repeat (ack_delay) @(negedge clk);
				if (exp_addr_q.size() == 0) begin
					report_other("memory request with no write expected");
				end else begin
					check_addr("mem_addr", mem_addr, exp_addr_q.pop_front());
					check_data("mem_data", mem_data, exp_data_q.pop_front());
				end
				handshakes++;
				mem_ack = 1'b1;
				@(negedge clk);
				while (mem_req)
					@(negedge clk);
				ack_delay = int'($unsigned($random(ack_seed)) % 4);
				repeat (ack_delay) @(negedge clk);  // Slow ack release
				mem_ack = 1'b0;
			end
		end
	end

	// Four-phase order seen from the bus
	always @(posedge clk) begin
		if (!reset_nes) begin
			if (mem_req && !prev_req && prev_ack)
				report_other("mem_req raised while mem_ack was still high");
			if (!mem_req && prev_req && !prev_ack)
				report_other("mem_req dropped before mem_ack was seen");
		end
		prev_req <= mem_req;
		prev_ack <= mem_ack;
	end

	task automatic run_load(input int idx);
		logic [127:0]          h;
		logic [7:0]            b;
		logic [MEM_ADDR_W-1:0] a;
		int                    n_prg;
		int                    n_chr;
		int                    hold;
		h = hdr_q[idx];
		n_prg = ok_q[idx] ? int'(h[127-32 -: 8]) * PRG_PAGE_BYTES : 0;
		n_chr = ok_q[idx] ? int'(h[127-40 -: 8]) * CHR_PAGE_BYTES : 0;
		handshakes = 0;
		invert_mirroring = inv_q[idx];
		downloading = 1'b1;
		@(negedge clk);
		check_status("console_reset", console_reset, 1'b1);
		for (int i = 0; i < HEADER_BYTES; i++)
			send_byte(h[127-8*i -: 8]);
		check_flags("mapper_flags", mapper_flags, mapper_flags_t'(0));  // Zero while loading
		check_status("loader_busy", loader_busy, ok_q[idx] && (n_prg + n_chr != 0));
		for (int i = 0; i < n_prg + n_chr; i++) begin
			b = 8'($random(data_seed));
			a = (i < n_prg) ? PRG_BASE + MEM_ADDR_W'(i) : CHR_BASE + MEM_ADDR_W'(i - n_prg);
			exp_addr_q.push_back(a);
			exp_data_q.push_back(b);
			send_byte(b);
		end
		if (!ok_q[idx]) begin
			for (int i = 0; i < 4; i++)
				send_byte(8'hA0 + 8'(i));   // Trailing bytes must be dropped
		end
		while (!loader_done)
			@(negedge clk);
		while (byte_wait || mem_req || mem_ack)
			@(negedge clk);
		check_status("loader_fail", loader_fail, !ok_q[idx]);
		check_status("loader_busy", loader_busy, 1'b0);
		check_count("handshakes", handshakes, n_prg + n_chr);
		if (exp_addr_q.size() != 0)
			report_other("load finished with writes still missing");
		downloading = 1'b0;
		hold = 0;
		if (ok_q[idx]) begin
			while (console_reset) begin
				@(negedge clk);
				hold++;
			end
			if (hold < DOWNLOAD_HOLD_CYCLES)
				report_other("console reset released before the hold count ran out");
			check_flags("mapper_flags", mapper_flags, flg_q[idx]);
		end else begin
			repeat (DOWNLOAD_HOLD_CYCLES + 20) @(negedge clk);
			check_status("console_reset", console_reset, 1'b1);
		end
	endtask

	task automatic run_pad(input int idx);
		logic [23:0] got0;
		logic [23:0] got1;
		{pad_a, pad_b, pad_c, pad_d} = pads_q[idx];
		multitap      = mt_q[idx];
		swap          = sw_q[idx];
		joypad_strobe = 1'b1;
		@(negedge clk);
		joypad_strobe = 1'b0;
		for (int k = 0; k < 24; k++) begin
			got0[k] = joypad_data[0];
			got1[k] = joypad_data[1];
			joypad_clock = 2'b00;
			@(negedge clk);
			joypad_clock = 2'b11;
			@(negedge clk);
		end
		check_pad_bits("joypad_data[0]", got0, exp0_q[idx]);
		check_pad_bits("joypad_data[1]", got1, exp1_q[idx]);
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		reset_nes        = 1'b1;
		downloading      = 1'b0;
		byte_valid       = 1'b0;
		byte_data        = 8'h00;
		invert_mirroring = 1'b0;
		mem_ack          = 1'b0;
		joypad_strobe    = 1'b0;
		joypad_clock     = 2'b11;  // Idle high
		multitap         = 1'b0;
		swap             = 1'b0;
		pad_a            = 8'h00;
		pad_b            = 8'h00;
		pad_c            = 8'h00;
		pad_d            = 8'h00;
		read_trace();
		for (int i = 0; i < hdr_q.size(); i++) begin
			cycle_limit += 12 * HEADER_BYTES;
			if (ok_q[i])
				cycle_limit += 12 * (int'(hdr_q[i][127-32 -: 8]) * PRG_PAGE_BYTES +
				                     int'(hdr_q[i][127-40 -: 8]) * CHR_PAGE_BYTES);
			else
				cycle_limit += 12 * 4;
		end
		repeat (5) @(negedge clk);
		reset_nes = 1'b0;
		@(negedge clk);
		check_status("console_reset", console_reset, 1'b1);
		check_status("mem_req", mem_req, 1'b0);
		check_status("byte_wait", byte_wait, 1'b0);
		check_status("loader_busy", loader_busy, 1'b0);
		check_status("loader_done", loader_done, 1'b0);
		check_status("loader_fail", loader_fail, 1'b0);
		for (int i = 0; i < hdr_q.size(); i++)
			run_load(i);
		for (int i = 0; i < pads_q.size(); i++)
			run_pad(i);
		print_summary();
		if (value_errors == 0 && other_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// File: verilog/ines_decode.sv
`timescale 1ns/1ns
// iNES header decoder
// Magic word and trainer check, page counts to size codes, mapper flag word

module ines_decode import nes_pkg::*; (
	input  logic [8*HEADER_BYTES-1:0] header,
	input  logic                      invert_mirroring,
	output logic                      header_ok,
	output mapper_flags_t             flags
);

	logic [7:0] hdr [HEADER_BYTES];
	logic       is_nes20;
	logic       is_dirty;

	// Page count to log2 size code, anything above 64 pages saturates
	function automatic logic [2:0] size_code(input logic [7:0] pages);
		logic [2:0] code;
		code = 3'd7;
		for (int i = 6; i >= 0; i--) begin
			if (pages <= (9'd1 << i))
				code = 3'(i);
		end
		return code;
	endfunction

	always_comb begin
		for (int i = 0; i < HEADER_BYTES; i++)
			hdr[i] = header[8*i +: 8];
	end

	assign is_nes20 = (hdr[7][3:2] == 2'b10);

	// Junk in bytes 9 to 15 of an old header, upper mapper nibble can't be trusted
	assign is_dirty = !is_nes20 &&
	                  ((hdr[9][7:1] != 7'd0) || (header[8*HEADER_BYTES-1:8*10] != '0));

	// No trainer support
	assign header_ok = ({hdr[0], hdr[1], hdr[2], hdr[3]} == INES_MAGIC) && !hdr[6][2];

	always_comb begin
		flags             = '0;
		flags.mapper      = {is_dirty ? 4'h0 : hdr[7][7:4], hdr[6][7:4]};
		flags.prg_size    = size_code(hdr[4]);
		flags.chr_size    = size_code(hdr[5]);
		flags.mirroring   = hdr[6][0] ^ invert_mirroring;
		flags.chr_ram     = (hdr[5] == 8'd0);    // No CHR pages
		flags.four_screen = hdr[6][3];
		flags.nes2_mapper = is_nes20 ? hdr[8] : 8'h00;
		flags.has_saves   = hdr[6][1];           // Battery bit
	end

endmodule

// File: verilog/joypad_serializer.sv
`timescale 1ns/1ns
// Controller port serializer for both NES joypad ports
// Strobe latching, four player multitap signatures and port swap

module joypad_serializer import nes_pkg::*; (
	input  logic       clk,
	input  logic       reset_nes,
	input  logic       joypad_strobe,
	input  logic       multitap,
	input  logic       swap,
	input  logic [1:0] joypad_clock,
	input  pad_t       pad_a,
	input  pad_t       pad_b,
	input  pad_t       pad_c,
	input  pad_t       pad_d,
	output logic [1:0] joypad_data
);

	logic [PAD_SHIFT_W-1:0] load_val [2];
	logic [PAD_SHIFT_W-1:0] shift_q  [2];
	logic [1:0]             clock_q;
	logic [1:0]             clock_fell;

	// Host order to NES order, A first out
	function automatic pad_t nes_order(input pad_t p);
		return {p[0], p[1], p[2], p[3], p[7], p[6], p[5], p[4]};
	endfunction

	assign clock_fell = clock_q & ~joypad_clock;

	// Without multitap the upper bits read back as ones
	always_comb begin
		load_val[0] = {multitap ? {MULTITAP_SIG_A, nes_order(pad_c)} : 16'hFFFF,
		               swap ? nes_order(pad_b) : nes_order(pad_a)};
		load_val[1] = {multitap ? {MULTITAP_SIG_B, nes_order(pad_d)} : 16'hFFFF,
		               swap ? nes_order(pad_a) : nes_order(pad_b)};
	end

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			clock_q <= '0;
			for (int i = 0; i < 2; i++)
				shift_q[i] <= '0;
		end else begin
			clock_q <= joypad_clock;
			for (int i = 0; i < 2; i++) begin
				if (joypad_strobe)
					shift_q[i] <= load_val[i];   // Strobe keeps reloading
				else if (clock_fell[i])
					shift_q[i] <= {1'b0, shift_q[i][PAD_SHIFT_W-1:1]};
			end
		end
	end

	assign joypad_data = {shift_q[1][0], shift_q[0][0]};

endmodule

// File: verilog/mem_write_port.sv
`timescale 1ns/1ns
// Single entry write buffer toward cartridge memory
// Four-phase req/ack handshake and wait signal to the byte source

module mem_write_port import nes_pkg::*; (
	input  logic                  clk,
	input  logic                  reset_nes,
	input  logic                  wr_strobe,
	input  logic                  mem_ack,
	input  logic [MEM_ADDR_W-1:0] wr_addr,
	input  logic [7:0]            wr_data,
	output logic                  mem_req,
	output logic                  byte_wait,
	output logic [MEM_ADDR_W-1:0] mem_addr,
	output logic [7:0]            mem_data
);

	// byte_wait with mem_req low means the ack is being waited out
	always_ff @(posedge clk) begin
		if (reset_nes) begin
			mem_req   <= 1'b0;
			byte_wait <= 1'b0;
		end else if (wr_strobe) begin
			mem_req   <= 1'b1;
			byte_wait <= 1'b1;
		end else begin
			if (mem_req && mem_ack)
				mem_req <= 1'b0;               // Phase 3, drop request
			if (byte_wait && !mem_req && !mem_ack)
				byte_wait <= 1'b0;             // Phase 4 seen, source may continue
		end
	end

	always_ff @(posedge clk) begin
		if (wr_strobe) begin
			mem_addr <= wr_addr;
			mem_data <= wr_data;
		end
	end

	// Request payload must not move until the request drops
	a_req_stable: assert property (@(posedge clk) disable iff (reset_nes)
		mem_req |=> !mem_req || ($stable(mem_addr) && $stable(mem_data)));

	// Source honours the wait, one buffer entry only
	a_no_overrun: assert property (@(posedge clk) disable iff (reset_nes)
		byte_wait |-> !wr_strobe);

endmodule

// File: verilog/nes_loader_top.sv
`timescale 1ns/1ns
// Cartridge loader and controller top level
// Loader, memory write port, session control and joypad serializer

module nes_loader_top import nes_pkg::*; (
	input  logic                  clk,
	input  logic                  reset_nes,
	// Byte source
	input  logic                  downloading,
	input  logic                  byte_valid,
	input  logic [7:0]            byte_data,
	input  logic                  invert_mirroring,
	output logic                  byte_wait,
	// Cartridge memory
	output logic                  mem_req,
	input  logic                  mem_ack,
	output logic [MEM_ADDR_W-1:0] mem_addr,
	output logic [7:0]            mem_data,
	// Load status and console
	output logic                  loader_busy,
	output logic                  loader_done,
	output logic                  loader_fail,
	output logic                  console_reset,
	output mapper_flags_t         mapper_flags,
	// Controllers
	input  logic                  joypad_strobe,
	input  logic [1:0]            joypad_clock,
	input  logic                  multitap,
	input  logic                  swap,
	input  pad_t                  pad_a,
	input  pad_t                  pad_b,
	input  pad_t                  pad_c,
	input  pad_t                  pad_d,
	output logic [1:0]            joypad_data
);

	logic                  wr_strobe;
	logic [MEM_ADDR_W-1:0] wr_addr;
	logic [7:0]            wr_data;
	mapper_flags_t         loader_flags;

	////////////////////////////////////////////////////////////
	// Loading path
	////////////////////////////////////////////////////////////

	rom_loader u_loader (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.downloading      (downloading),
		.byte_valid       (byte_valid),
		.invert_mirroring (invert_mirroring),
		.byte_data        (byte_data),
		.wr_strobe        (wr_strobe),
		.busy             (loader_busy),
		.done             (loader_done),
		.fail             (loader_fail),
		.wr_addr          (wr_addr),
		.wr_data          (wr_data),
		.flags            (loader_flags)
	);

	mem_write_port u_wport (
		.clk       (clk),
		.reset_nes (reset_nes),
		.wr_strobe (wr_strobe),
		.mem_ack   (mem_ack),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.mem_req   (mem_req),
		.byte_wait (byte_wait),
		.mem_addr  (mem_addr),
		.mem_data  (mem_data)
	);

	session_control u_session (
		.clk           (clk),
		.reset_nes     (reset_nes),
		.downloading   (downloading),
		.loader_busy   (loader_busy),
		.loader_done   (loader_done),
		.loader_fail   (loader_fail),
		.loader_flags  (loader_flags),
		.console_reset (console_reset),
		.mapper_flags  (mapper_flags)
	);

	// Controller ports
	joypad_serializer u_joypad (
		.clk           (clk),
		.reset_nes     (reset_nes),
		.joypad_strobe (joypad_strobe),
		.multitap      (multitap),
		.swap          (swap),
		.joypad_clock  (joypad_clock),
		.pad_a         (pad_a),
		.pad_b         (pad_b),
		.pad_c         (pad_c),
		.pad_d         (pad_d),
		.joypad_data   (joypad_data)
	);

endmodule

// File: verilog/nes_pkg.sv
// Shared constants and types for the NES cartridge loader
// Memory layout, iNES header layout, console hold count and controller values
// Mapper flag word, loader state and controller byte types

package nes_pkg;

	////////////////////////////////////////////////////////////
	// Cartridge memory layout
	////////////////////////////////////////////////////////////

	localparam int                    MEM_ADDR_W     = 22;
	localparam logic [MEM_ADDR_W-1:0] PRG_BASE       = 22'h000000;  // PRG ROM at bottom
	localparam logic [MEM_ADDR_W-1:0] CHR_BASE       = 22'h200000;  // CHR ROM in top half
	localparam int                    PRG_PAGE_BYTES = 16384;
	localparam int                    CHR_PAGE_BYTES = 8192;

	// iNES header
	localparam int          HEADER_BYTES = 16;
	localparam int          HDR_CNT_W    = $clog2(HEADER_BYTES);
	localparam logic [31:0] INES_MAGIC   = 32'h4E45531A;  // "NES" followed by 0x1A

	// Console hold after a download
	localparam int DOWNLOAD_HOLD_CYCLES = 255;
	localparam int HOLD_CNT_W           = $clog2(DOWNLOAD_HOLD_CYCLES + 1);

	////////////////////////////////////////////////////////////
	// Types
	////////////////////////////////////////////////////////////

	// Mapper flag word, fields listed from the top bit down
	typedef struct packed {
		logic [5:0] zero;
		logic       has_saves;
		logic [7:0] nes2_mapper;
		logic       four_screen;
		logic       chr_ram;
		logic       mirroring;
		logic [2:0] chr_size;   // log2 of 8K pages
		logic [2:0] prg_size;   // log2 of 16K pages
		logic [7:0] mapper;
	} mapper_flags_t;

	typedef enum logic [2:0] {
		LOAD_HEADER,
		LOAD_PRG,
		LOAD_CHR,
		LOAD_DONE,
		LOAD_ERROR
	} loader_state_t;

	typedef logic [7:0] pad_t;  // Host button order

	// Controllers
	localparam int   PAD_SHIFT_W    = 24;     // Pad, multitap pad, signature
	localparam pad_t MULTITAP_SIG_A = 8'h08;  // Port one signature
	localparam pad_t MULTITAP_SIG_B = 8'h04;  // Port two signature

endpackage

// File: verilog/rom_loader.sv
`timescale 1ns/1ns
// iNES byte stream loader
// Header capture, PRG and CHR address generation, load status

module rom_loader import nes_pkg::*; (
	input  logic                  clk,
	input  logic                  reset_nes,
	input  logic                  downloading,
	input  logic                  byte_valid,
	input  logic                  invert_mirroring,
	input  logic [7:0]            byte_data,
	output logic                  wr_strobe,
	output logic                  busy,
	output logic                  done,
	output logic                  fail,
	output logic [MEM_ADDR_W-1:0] wr_addr,
	output logic [7:0]            wr_data,
	output mapper_flags_t         flags
);

	loader_state_t             state;
	logic [HDR_CNT_W-1:0]      hdr_cnt;
	logic [HDR_CNT_W-1:0]      hdr_idx;
	logic [8*HEADER_BYTES-1:0] header_q;
	logic [8*HEADER_BYTES-1:0] header_next;
	logic [MEM_ADDR_W-1:0]     next_addr;
	logic [MEM_ADDR_W-1:0]     bytes_left;
	logic [MEM_ADDR_W-1:0]     prg_bytes;
	logic [MEM_ADDR_W-1:0]     chr_bytes;
	logic                      downloading_q;
	logic                      start;
	logic                      take;
	logic                      hdr_we;
	logic                      data_we;
	logic                      header_last;
	logic                      header_ok;

	assign start   = downloading && !downloading_q;  // New file restarts the loader
	assign take    = byte_valid && downloading;
	assign hdr_idx = start ? '0 : hdr_cnt;
	assign hdr_we  = take && (start || state == LOAD_HEADER);
	assign data_we = take && !start && (state == LOAD_PRG || state == LOAD_CHR);

	assign header_last = hdr_we && (hdr_idx == HDR_CNT_W'(HEADER_BYTES - 1));

	// Header with the incoming byte merged, so the last byte decodes without a gap
	always_comb begin
		header_next = header_q;
		if (hdr_we)
			header_next[8*hdr_idx +: 8] = byte_data;
	end

	assign prg_bytes = MEM_ADDR_W'(32'(header_next[8*4 +: 8]) * PRG_PAGE_BYTES);
	assign chr_bytes = MEM_ADDR_W'(32'(header_next[8*5 +: 8]) * CHR_PAGE_BYTES);

	ines_decode u_decode (
		.header           (header_next),
		.invert_mirroring (invert_mirroring),
		.header_ok        (header_ok),
		.flags            (flags)
	);

	////////////////////////////////////////////////////////////
	// Load sequence
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state         <= LOAD_HEADER;
			hdr_cnt       <= '0;
			next_addr     <= PRG_BASE;
			bytes_left    <= '0;
			downloading_q <= 1'b0;
			wr_strobe     <= 1'b0;
			busy          <= 1'b0;
			done          <= 1'b0;
			fail          <= 1'b0;
		end else begin
			downloading_q <= downloading;
			wr_strobe     <= data_we;

			if (start) begin
				state <= LOAD_HEADER;
				busy  <= 1'b0;
				done  <= 1'b0;
				fail  <= 1'b0;
			end

			if (hdr_we)
				hdr_cnt <= hdr_idx + 1'b1;
			else if (start)
				hdr_cnt <= '0;

			if (header_last) begin
				if (!header_ok) begin
					state <= LOAD_ERROR;
					done  <= 1'b1;
					fail  <= 1'b1;
				end else if (prg_bytes != '0) begin
					state      <= LOAD_PRG;
					next_addr  <= PRG_BASE;
					bytes_left <= prg_bytes;
					busy       <= 1'b1;
				end else if (chr_bytes != '0) begin
					state      <= LOAD_CHR;
					next_addr  <= CHR_BASE;
					bytes_left <= chr_bytes;
					busy       <= 1'b1;
				end else begin
					state <= LOAD_DONE;          // Header only, CHR RAM cart
					done  <= 1'b1;
				end
			end

			if (data_we) begin
				next_addr  <= next_addr + 1'b1;
				bytes_left <= bytes_left - 1'b1;
				if (bytes_left == MEM_ADDR_W'(1)) begin
					if (state == LOAD_PRG && chr_bytes != '0) begin
						state      <= LOAD_CHR;
						next_addr  <= CHR_BASE;
						bytes_left <= chr_bytes;
					end else begin
						state <= LOAD_DONE;
						busy  <= 1'b0;
						done  <= 1'b1;
					end
				end
			end
		end
	end

	// Header and write payload
	always_ff @(posedge clk) begin
		if (hdr_we)
			header_q <= header_next;
		if (data_we) begin
			wr_addr <= next_addr;
			wr_data <= byte_data;
		end
	end

	// Header bytes never reach memory
	a_no_header_write: assert property (@(posedge clk) disable iff (reset_nes)
		wr_strobe |-> state != LOAD_HEADER);

endmodule

// File: verilog/session_control.sv
`timescale 1ns/1ns
// Console hold reset and mapper flag latch

module session_control import nes_pkg::*; (
	input  logic          clk,
	input  logic          reset_nes,
	input  logic          downloading,
	input  logic          loader_busy,
	input  logic          loader_done,
	input  logic          loader_fail,
	input  mapper_flags_t loader_flags,
	output logic          console_reset,
	output mapper_flags_t mapper_flags
);

	logic                  init_done;  // First download seen
	logic [HOLD_CNT_W-1:0] hold_cnt;
	logic                  done_q;
	mapper_flags_t         flags_q;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			init_done <= 1'b0;
			hold_cnt  <= '0;
			done_q    <= 1'b0;
			flags_q   <= '0;
		end else begin
			done_q <= loader_done;
			if (downloading)
				init_done <= 1'b1;
			if (downloading)
				hold_cnt <= HOLD_CNT_W'(DOWNLOAD_HOLD_CYCLES);
			else if (!loader_busy && hold_cnt != '0)
				hold_cnt <= hold_cnt - 1'b1;   // Runs only once the loader is idle
			if (loader_done && !done_q)
				flags_q <= loader_flags;
		end
	end

	assign console_reset = !init_done || downloading || (hold_cnt != '0) || loader_fail;
	assign mapper_flags  = downloading ? mapper_flags_t'('0) : flags_q;

endmodule
